// File: Makefile
# Verilator build and run of the ICCM testbench
# override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= iccm_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

# builds, runs, and fails unless the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: logic/iccm_array.sv
/*
  word memory with a masked write port for boot loading and a registered
  bus read path, read data valid one cycle after the command
  load writes are only honoured while load_done_i is low
  no reset on the array, contents are undefined until loaded
*/
`timescale 1ns/1ps

module iccm_array #(
    parameter int MemWords = 1024
) (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  iccm_pkg::load_req_t           load_i,
    input  logic                          load_done_i,
    input  iccm_pkg::mem_cmd_t            cmd_i,
    input  iccm_pkg::mem_ctx_t            ctx_i,
    output logic [iccm_pkg::DataWidth-1:0] rdata_o,
    output iccm_pkg::mem_ctx_t            ctx_o
);

    localparam int IdxWidth = $clog2(MemWords);

    logic [iccm_pkg::DataWidth-1:0] mem_q [MemWords];
    logic [iccm_pkg::DataWidth-1:0] rdata_q;
    logic                           load_we;
    logic [IdxWidth-1:0]            load_idx;
    logic [IdxWidth-1:0]            rd_idx;
    iccm_pkg::mem_ctx_t             ctx_q;

    assign load_we  = load_i.we && !load_done_i;  // port is dead once handed to the bus
    assign load_idx = load_i.addr[IdxWidth-1:0];
    assign rd_idx   = cmd_i.index[IdxWidth-1:0];  // range already checked in decode

    // byte-masked load write
    always_ff @(posedge clk_i) begin
        if (load_we) begin
            for (int b = 0; b < iccm_pkg::MaskWidth; b++) begin
                if (load_i.mask[b]) begin
                    mem_q[load_idx][8*b +: 8] <= load_i.data[8*b +: 8];
                end
            end
        end
    end

    // single port read, only real accesses touch the array
    always_ff @(posedge clk_i) begin
        if (cmd_i.valid && cmd_i.access) begin
            rdata_q <= mem_q[rd_idx];
        end
    end

    // context rides one cycle behind, matching read latency
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            ctx_q.valid <= 1'b0;
        end else if (load_we) begin
            ctx_q.valid <= 1'b0;  // read data invalid while writing
        end else begin
            ctx_q.valid <= ctx_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        ctx_q.source   <= ctx_i.source;
        ctx_q.error    <= ctx_i.error;
        ctx_q.has_data <= ctx_i.has_data;
    end

    assign rdata_o = rdata_q;
    assign ctx_o   = ctx_q;

    // single-ported: decode must keep the bus off while loading
    a_no_load_bus_overlap : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        load_we |-> !cmd_i.valid
    ) else $error("load write collides with bus command");

endmodule

// File: logic/iccm_pkg.sv
/*
  shared widths, TL-UL opcodes and the structs that travel between the stages
  simplified TL-UL: single-beat word accesses only, no integrity bits
  load port address is fixed at 11 bits, so MemWords may not exceed 2048
*/
package iccm_pkg;

    parameter int DataWidth     = 32;
    parameter int AddrWidth     = 32;             // byte address on the bus
    parameter int SourceWidth   = 8;
    parameter int MaskWidth     = DataWidth / 8;  // one bit per byte lane
    parameter int LoadAddrWidth = 11;             // word address on the load port
    parameter int WordIdxWidth  = LoadAddrWidth;  // index carried to the array

    // A channel opcodes, TL-UL encoding
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } tl_a_op_e;

    // D channel opcodes
    typedef enum logic [2:0] {
        AccessAck     = 3'h0,
        AccessAckData = 3'h1
    } tl_d_op_e;

    typedef struct packed {
        logic                   a_valid;
        tl_a_op_e               opcode;
        logic [AddrWidth-1:0]   address;
        logic [MaskWidth-1:0]   mask;
        logic [DataWidth-1:0]   data;
        logic [SourceWidth-1:0] source;
    } tl_req_t;

    typedef struct packed {
        logic                   d_valid;
        tl_d_op_e               opcode;
        logic [DataWidth-1:0]   data;
        logic [SourceWidth-1:0] source;
        logic                   error;
    } tl_rsp_t;

    // boot-time programming port
    typedef struct packed {
        logic                     we;
        logic [LoadAddrWidth-1:0] addr;   // word address
        logic [DataWidth-1:0]     data;
        logic [MaskWidth-1:0]     mask;   // byte enables
    } load_req_t;

    typedef struct packed {
        logic                    valid;
        logic                    access;  // low for rejected requests, no array read
        logic [WordIdxWidth-1:0] index;
    } mem_cmd_t;

    typedef struct packed {
        logic                   valid;
        logic [SourceWidth-1:0] source;
        logic                   error;
        logic                   has_data; // Get -> AccessAckData, else AccessAck
    } mem_ctx_t;

endpackage

// File: logic/iccm_req_decode.sv
/*
  A channel front end that accepts beats, flags rejected requests and
  registers the command and its context for the array stage
  a_ready_o only rises once loading is done and a response slot is free
  any opcode other than Get is rejected since the bus side is read-only
*/
`timescale 1ns/1ps

module iccm_req_decode #(
    parameter int MemWords = 1024,
    parameter int RspDepth = 2
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  iccm_pkg::tl_req_t tl_i,
    output logic              a_ready_o,
    input  logic              load_done_i,
    input  logic              rsp_pop_i,
    output iccm_pkg::mem_cmd_t cmd_o,
    output iccm_pkg::mem_ctx_t ctx_o
);

    localparam int CntWidth = $clog2(RspDepth + 1);

    logic                                  accept;
    logic                                  is_get;
    logic                                  misaligned;
    logic                                  out_of_range;
    logic                                  req_err;
    logic [iccm_pkg::AddrWidth-3:0]        word_addr;   // byte address >> 2
    logic [CntWidth-1:0]                   count_q;     // outstanding requests
    iccm_pkg::mem_cmd_t                    cmd_q;
    iccm_pkg::mem_ctx_t                    ctx_q;

    // a slot freed this cycle may be reused right away
    assign a_ready_o = load_done_i && ((count_q < CntWidth'(RspDepth)) || rsp_pop_i);
    assign accept    = tl_i.a_valid && a_ready_o;

    assign word_addr    = tl_i.address[iccm_pkg::AddrWidth-1:2];
    assign is_get       = (tl_i.opcode == iccm_pkg::Get);
    assign misaligned   = (tl_i.address[1:0] != 2'b00);
    assign out_of_range = (word_addr >= MemWords);
    assign req_err      = !is_get || misaligned || out_of_range;  // puts are write-protected

    // command and context valids
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            cmd_q.valid  <= 1'b0;
            cmd_q.access <= 1'b0;
            ctx_q.valid  <= 1'b0;
        end else begin
            cmd_q.valid  <= accept;
            cmd_q.access <= accept && !req_err;  // errors bypass the array
            ctx_q.valid  <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q.index    <= word_addr[iccm_pkg::WordIdxWidth-1:0];
            ctx_q.source   <= tl_i.source;
            ctx_q.error    <= req_err;
            ctx_q.has_data <= is_get;  // rejected Get still answers with data
        end
    end

    // outstanding count goes up on accept and down on each D transfer
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (accept && !rsp_pop_i) begin
            count_q <= count_q + 1'b1;
        end else if (!accept && rsp_pop_i) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign cmd_o = cmd_q;
    assign ctx_o = ctx_q;

    // a pop without anything outstanding means the count and queue disagree
    a_pop_needs_outstanding : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        rsp_pop_i |-> (count_q != '0)
    ) else $error("response popped with no request outstanding");

endmodule

// File: logic/iccm_rsp_gen.sv
/*
  builds D channel responses and returns them in request order
  queue head is shown combinationally, an empty queue passes the new response
  straight through so it appears in the cycle its read data arrives
  RspDepth entries, overflow is prevented by the slot count in decode
*/
`timescale 1ns/1ps

module iccm_rsp_gen #(
    parameter int RspDepth = 2
) (
    input  logic                           clk_i,
    input  logic                           rst_ni,
    input  logic [iccm_pkg::DataWidth-1:0] rdata_i,
    input  iccm_pkg::mem_ctx_t             ctx_i,
    input  logic                           d_ready_i,
    output iccm_pkg::tl_rsp_t              tl_o,
    output logic                           rsp_pop_o
);

    localparam int PtrWidth = (RspDepth > 1) ? $clog2(RspDepth) : 1;
    localparam int CntWidth = $clog2(RspDepth + 1);

    iccm_pkg::tl_rsp_t   rsp_new;
    iccm_pkg::tl_rsp_t   fifo_q [RspDepth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                empty;
    logic                full;
    logic                bypass;   // new response leaves without being stored
    logic                push;
    logic                pop;

    // response formatting
    always_comb begin
        rsp_new.d_valid = ctx_i.valid;
        rsp_new.opcode  = ctx_i.has_data ? iccm_pkg::AccessAckData : iccm_pkg::AccessAck;
        rsp_new.data    = (ctx_i.has_data && !ctx_i.error) ? rdata_i : '0;  // zero on error
        rsp_new.source  = ctx_i.source;
        rsp_new.error   = ctx_i.error;
    end

    assign empty  = (count_q == '0);
    assign full   = (count_q == CntWidth'(RspDepth));
    assign bypass = empty && ctx_i.valid && d_ready_i;
    assign push   = ctx_i.valid && !bypass;
    assign pop    = !empty && d_ready_i;  // head leaves from storage

    // head of queue, or the incoming response when nothing is waiting
    always_comb begin
        tl_o         = empty ? rsp_new : fifo_q[rd_ptr_q];
        tl_o.d_valid = !empty || ctx_i.valid;
    end

    assign rsp_pop_o = tl_o.d_valid && d_ready_i;  // one pulse per D beat

    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= rsp_new;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrWidth'(RspDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrWidth'(RspDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // holds only if decode never lets more than RspDepth requests out
    a_no_push_when_full : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (push && full) |-> pop
    ) else $error("response pushed into a full queue");

endmodule

// File: logic/iccm_subsys.sv
/*
  ICCM behind a simplified TL-UL device port
  load port programs the array until load_done_i, then the bus owns it
  Get only, puts and bad addresses return an error response
  at most RspDepth requests in flight, two cycle read latency
*/
`timescale 1ns/1ps

module iccm_subsys #(
    parameter int MemWords = 1024,  // 32-bit words, at most 2048
    parameter int RspDepth = 2      // response slots = outstanding limit
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  iccm_pkg::tl_req_t   tl_i,
    output logic                a_ready_o,
    output iccm_pkg::tl_rsp_t   tl_o,
    input  logic                d_ready_i,
    input  iccm_pkg::load_req_t load_i,
    input  logic                load_done_i
);

    iccm_pkg::mem_cmd_t             mem_cmd;
    iccm_pkg::mem_ctx_t             dec_ctx;     // decode -> array
    iccm_pkg::mem_ctx_t             arr_ctx;     // array -> rsp_gen, one cycle later
    logic [iccm_pkg::DataWidth-1:0] arr_rdata;
    logic                           rsp_pop;     // D beat taken

    iccm_req_decode #(
        .MemWords (MemWords),
        .RspDepth (RspDepth)
    ) i_iccm_req_decode (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .tl_i        (tl_i),
        .a_ready_o   (a_ready_o),
        .load_done_i (load_done_i),
        .rsp_pop_i   (rsp_pop),
        .cmd_o       (mem_cmd),
        .ctx_o       (dec_ctx)
    );

    iccm_array #(
        .MemWords (MemWords)
    ) i_iccm_array (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .load_i      (load_i),
        .load_done_i (load_done_i),
        .cmd_i       (mem_cmd),
        .ctx_i       (dec_ctx),
        .rdata_o     (arr_rdata),
        .ctx_o       (arr_ctx)
    );

    iccm_rsp_gen #(
        .RspDepth (RspDepth)
    ) i_iccm_rsp_gen (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rdata_i   (arr_rdata),
        .ctx_i     (arr_ctx),
        .d_ready_i (d_ready_i),
        .tl_o      (tl_o),
        .rsp_pop_o (rsp_pop)
    );

endmodule

// File: sources.f
logic/iccm_pkg.sv
logic/iccm_req_decode.sv
logic/iccm_array.sv
logic/iccm_rsp_gen.sv
logic/iccm_subsys.sv
verification/iccm_tb.sv

// File: verification/iccm_tb.sv
/*
  directed testbench for iccm_subsys, stops at the first mismatch
  assumes MemWords is a power of two, random word indices are masked to fit
*/
`timescale 1ns/1ps

module iccm_tb;

    localparam int MemWords      = 1024;
    localparam int RspDepth      = 2;
    localparam int IdxWidth      = $clog2(MemWords);
    localparam int TimeoutCycles = 2 * (MemWords + 1500);  // load pass plus tests, doubled

    logic                clk_i;
    logic                rst_ni;
    iccm_pkg::tl_req_t   tl_i;
    logic                a_ready_o;
    iccm_pkg::tl_rsp_t   tl_o;
    logic                d_ready_i;
    iccm_pkg::load_req_t load_i;
    logic                load_done_i;

    logic [31:0]       model [MemWords];  // mirrors every load write
    iccm_pkg::tl_rsp_t exp_q [$];         // pushed on A acceptance
    iccm_pkg::tl_rsp_t got_q [$];         // pushed on D transfer
    int                acc_edge_q [$];
    int                got_edge_q [$];
    int                checked    = 0;    // responses already compared
    int                cycles     = 0;
    int                errors     = 0;
    int                seed       = 32'h716c;
    logic              rand_ready = 1'b0; // d_ready_i toggles randomly when set

    iccm_subsys #(
        .MemWords (MemWords),
        .RspDepth (RspDepth)
    ) i_iccm_subsys (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .tl_i        (tl_i),
        .a_ready_o   (a_ready_o),
        .tl_o        (tl_o),
        .d_ready_i   (d_ready_i),
        .load_i      (load_i),
        .load_done_i (load_done_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TimeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
            fail_run();
        end
    end

    // sampled mid-cycle, the beat transfers at the next edge
    always @(negedge clk_i) begin
        if (rst_ni && tl_o.d_valid && d_ready_i) begin
            got_q.push_back(tl_o);
            got_edge_q.push_back(cycles + 1);
        end
    end

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at time %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            fail_run();
        end
    endtask

    // all stimulus changes 1 ns after the rising edge
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge clk_i);
        #1;
        if (rand_ready) begin
            rnd = $random(seed);
            d_ready_i = rnd[0];
        end
    endtask

    // expected D beat from the TL-UL rules and the model
    function automatic iccm_pkg::tl_rsp_t expect_rsp(input iccm_pkg::tl_a_op_e op,
                                                     input logic [31:0] addr,
                                                     input logic [7:0] src);
        iccm_pkg::tl_rsp_t r;
        logic              err;
        err = (op != iccm_pkg::Get) || (addr[1:0] != 2'b00) || ((addr >> 2) >= 32'(MemWords));
        r.d_valid = 1'b1;
        r.opcode  = (op == iccm_pkg::Get) ? iccm_pkg::AccessAckData : iccm_pkg::AccessAck;
        r.data    = err ? 32'h0 : model[addr[IdxWidth+1:2]];  // no data on error
        r.source  = src;
        r.error   = err;
        return r;
    endfunction

    task automatic drive_a(input iccm_pkg::tl_a_op_e op, input logic [31:0] addr,
                           input logic [7:0] src);
        tl_i.a_valid = 1'b1;
        tl_i.opcode  = op;
        tl_i.address = addr;
        tl_i.mask    = (op == iccm_pkg::PutPartialData) ? 4'h3 : 4'hf;
        tl_i.data    = ~addr;  // fixed per address so a held beat stays stable
        tl_i.source  = src;
    endtask

    // holds the beat until a_ready_o, records what must come back
    task automatic send_req(input iccm_pkg::tl_a_op_e op, input logic [31:0] addr,
                            input logic [7:0] src);
        logic taken;
        taken = 1'b0;
        drive_a(op, addr, src);
        while (!taken) begin
            @(negedge clk_i);
            if (a_ready_o) begin
                taken = 1'b1;
                exp_q.push_back(expect_rsp(op, addr, src));
                acc_edge_q.push_back(cycles + 1);
            end
            next_cycle();
        end
        tl_i.a_valid = 1'b0;
    endtask

    task automatic wait_responses(input logic check_timing);
        while (got_q.size() < exp_q.size()) begin
            next_cycle();
        end
        next_cycle();  // a stray extra beat would land here
        check_val("response count", 32'(got_q.size()), 32'(exp_q.size()));
        for (int i = checked; i < exp_q.size(); i++) begin
            check_val("tl_o.opcode", 32'(got_q[i].opcode), 32'(exp_q[i].opcode));
            check_val("tl_o.data", got_q[i].data, exp_q[i].data);
            check_val("tl_o.source", 32'(got_q[i].source), 32'(exp_q[i].source));
            check_val("tl_o.error", 32'(got_q[i].error), 32'(exp_q[i].error));
            if (check_timing) begin
                check_val("d_valid edge after accept", 32'(got_edge_q[i] - acc_edge_q[i]), 32'd2);
                check_val("accept edge", 32'(acc_edge_q[i] - acc_edge_q[checked]),
                          32'(i - checked));
            end
        end
        checked = exp_q.size();
    endtask

    task automatic load_word(input logic [IdxWidth-1:0] idx, input logic [31:0] data,
                             input logic [3:0] mask);
        logic [iccm_pkg::LoadAddrWidth-1:0] addr;
        addr           = '0;
        addr[IdxWidth-1:0] = idx;
        load_i.we      = 1'b1;
        load_i.addr    = addr;
        load_i.data    = data;
        load_i.mask    = mask;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) model[idx][8*b +: 8] = data[8*b +: 8];
        end
        @(negedge clk_i);
        check_val("a_ready_o", 32'(a_ready_o), 32'd0);       // bus locked out
        check_val("tl_o.d_valid", 32'(tl_o.d_valid), 32'd0);
        next_cycle();
    endtask

    // full load with a Get held on A the whole time, then hand over
    task automatic test_load_phase();
        logic [31:0] rnd;
        drive_a(iccm_pkg::Get, 32'h0, 8'h00);
        for (int i = 0; i < MemWords; i++) begin
            rnd = $random(seed);
            load_word(IdxWidth'(i), rnd, 4'hf);
        end
        for (int i = 0; i < 48; i++) begin  // partial masks over loaded words
            rnd = $random(seed);
            load_word(rnd[IdxWidth-1:0], $random(seed), rnd[31:28]);
        end
        load_i.we   = 1'b0;
        load_done_i = 1'b1;
        send_req(iccm_pkg::Get, 32'h0, 8'h00);  // the held beat now goes through
        wait_responses(1'b0);
    endtask

    task automatic test_read_back();
        logic [31:0] rnd;
        for (int i = 0; i < 64; i++) begin
            rnd = $random(seed);
            send_req(iccm_pkg::Get, 32'(rnd[IdxWidth-1:0]) << 2, rnd[31:24]);
        end
        wait_responses(1'b0);
    endtask

    task automatic test_write_protect();
        logic [31:0] rnd;
        logic [31:0] addr;
        rnd  = $random(seed);
        addr = 32'(rnd[IdxWidth-1:0]) << 2;
        send_req(iccm_pkg::PutFullData, addr, 8'h11);
        send_req(iccm_pkg::PutPartialData, addr, 8'h12);
        send_req(iccm_pkg::Get, addr, 8'h13);  // still the loaded word
        wait_responses(1'b0);
    endtask

    task automatic test_bad_address();
        logic [31:0] rnd;
        logic [31:0] addr;
        rnd  = $random(seed);
        addr = 32'(rnd[IdxWidth-1:0]) << 2;
        send_req(iccm_pkg::Get, addr | 32'h1, 8'h21);
        send_req(iccm_pkg::Get, addr | 32'h2, 8'h22);
        send_req(iccm_pkg::Get, addr | 32'h3, 8'h23);
        send_req(iccm_pkg::Get, 32'(MemWords) << 2, 8'h24);  // first word past the end
        send_req(iccm_pkg::Get, 32'hffff_fffc, 8'h25);
        wait_responses(1'b0);
    endtask

    task automatic test_back_pressure();
        logic [31:0] rnd;
        d_ready_i = 1'b0;
        for (int i = 0; i < RspDepth; i++) begin
            send_req(iccm_pkg::Get, 32'(i) << 2, 8'(48 + i));
        end
        drive_a(iccm_pkg::Get, 32'h40, 8'h3f);  // one too many, must stall
        repeat (4) begin
            @(negedge clk_i);
            check_val("a_ready_o", 32'(a_ready_o), 32'd0);
            next_cycle();
        end
        rand_ready = 1'b1;
        send_req(iccm_pkg::Get, 32'h40, 8'h3f);
        for (int i = 0; i < 8; i++) begin
            rnd = $random(seed);
            send_req(iccm_pkg::Get, 32'(rnd[IdxWidth-1:0]) << 2, 8'(64 + i));
        end
        wait_responses(1'b0);
        rand_ready = 1'b0;
        d_ready_i  = 1'b1;
    endtask

    // queue empty and d_ready_i high, back-to-back Gets
    task automatic test_latency();
        for (int i = 0; i < 8; i++) begin
            send_req(iccm_pkg::Get, 32'(i) << 2, 8'(128 + i));
        end
        wait_responses(1'b1);
    endtask

    initial begin
        rst_ni      = 1'b0;
        tl_i        = '0;
        load_i      = '0;
        load_done_i = 1'b0;
        d_ready_i   = 1'b1;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        test_load_phase();
        test_read_back();
        test_write_protect();
        test_bad_address();
        test_back_pressure();
        test_latency();
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
